/* logic/adc_reg_pkg.sv */
package adc_reg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // setup register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int num_setup_regs = 6;

  // index into the setup bank. only 0 to 5 select a register.
  typedef logic [2:0] reg_index_t;

  typedef logic [3:0] reg_addr_t; // address as the ADC decodes it.

  typedef logic [15:0] reg_data_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tables indexed by reg_index_t
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the sequencer writes the registers in this order.
  localparam reg_addr_t setup_addr_table [num_setup_regs] = '{
    4'h1,  // configuration.
    4'h2,  // offset.
    4'h3,  // full-scale voltage adjust.
    4'hC,  // fine phase.
    4'hD,  // coarse phase.
    4'hF   // test pattern.
  };

  // power-up values of the bank.
  // without host writes these are the words that reach the ADC.
  localparam reg_data_t setup_default_table [num_setup_regs] = '{
    16'h92FF,
    16'h007F,
    16'h807F,  // mid-scale full-scale adjust.
    16'h007F,
    16'h03FF,
    16'hFFFF   // test pattern off.
  };

endpackage

/* logic/serial_link_pkg.sv */
package serial_link_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // three-wire serial frame
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int frame_bits = 32;

  typedef logic [11:0] header_t; // fixed pattern that opens every frame.

  // one write frame. the header goes out first since the link is MSB first.
  typedef struct packed {
    header_t       header;
    logic [3:0]    addr;    // target register in the ADC.
    logic [15:0]   data;
  } serial_word_t;

endpackage

/* logic/adc_setup_regs.sv */
`timescale 1ns/1ps

module adc_setup_regs
  import adc_reg_pkg::*;
(
  input  logic       fsclk,
  input  logic       reset,
  input  logic       cfg_we,
  input  reg_index_t cfg_index,
  input  reg_data_t  cfg_data,
  input  logic       busy,
  input  reg_index_t reg_index,
  output reg_data_t  reg_data
);

  reg_data_t regs [num_setup_regs];

  logic cfg_index_ok;
  logic rd_index_ok;
  logic write_ok;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host write port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign cfg_index_ok = (cfg_index < reg_index_t'(num_setup_regs));

  // the bank is frozen while a sequence runs.
  // a frame's data word cannot change under the writer that way.
  assign write_ok = cfg_we && !busy && cfg_index_ok;

  always_ff @(posedge fsclk) begin
    if (reset) begin
      for (int i = 0; i < num_setup_regs; i++) begin
        regs[i] <= setup_default_table[i];
      end
    end else if (write_ok) begin
      regs[cfg_index] <= cfg_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencer read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd_index_ok = (reg_index < reg_index_t'(num_setup_regs));

  // combinational read so the frame word follows reg_index in the same cycle.
  always_comb begin
    if (rd_index_ok) begin
      reg_data = regs[reg_index];
    end else begin
      reg_data = '0; // unused indices read as zero.
    end
  end

endmodule

/* logic/adc_serial_setup.sv */
`timescale 1ns/1ps

module adc_serial_setup
  import adc_reg_pkg::*, serial_link_pkg::*;
#(
  parameter header_t header_pattern = 12'h001
) (
  input  logic         fsclk,
  input  logic         reset,
  input  logic         calibration_done,
  input  reg_data_t    reg_data,
  output reg_index_t   reg_index,
  output logic         busy,
  output serial_word_t word,
  output logic         start,
  input  logic         done,
  output logic         setup_done
);

  typedef enum logic [2:0] {
    st_idle,
    st_config,
    st_offset,
    st_vadj,
    st_phase_fine,
    st_phase_coarse,
    st_test_pattern,
    st_done
  } seq_state_t;

  seq_state_t state;
  seq_state_t next_state;
  seq_state_t after_frame;
  logic       in_frame;

  always_ff @(posedge fsclk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per-register decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // each frame state picks its register and the state that follows it.
  always_comb begin
    in_frame    = 1'b1;
    reg_index   = 3'd0;
    after_frame = st_done;
    case (state)
      st_config:       begin reg_index = 3'd0; after_frame = st_offset;       end
      st_offset:       begin reg_index = 3'd1; after_frame = st_vadj;         end
      st_vadj:         begin reg_index = 3'd2; after_frame = st_phase_fine;   end
      st_phase_fine:   begin reg_index = 3'd3; after_frame = st_phase_coarse; end
      st_phase_coarse: begin reg_index = 3'd4; after_frame = st_test_pattern; end
      st_test_pattern: begin reg_index = 3'd5; after_frame = st_done;         end
      default:         in_frame = 1'b0;
    endcase
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (calibration_done) begin
          next_state = st_config;
        end
      end
      st_done: next_state = st_done; // only reset starts another run.
      default: begin
        if (done) begin
          next_state = after_frame;
        end
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // writer handshake and status
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign word = '{
    header: header_pattern,
    addr:   setup_addr_table[reg_index],
    data:   reg_data
  };

  // start drops in the done cycle so the writer does not take the same frame twice.
  assign start      = in_frame && !done;
  assign busy       = in_frame;
  assign setup_done = (state == st_done);

endmodule

/* logic/adc_serial_writer.sv */
`timescale 1ns/1ps

module adc_serial_writer
  import serial_link_pkg::*;
#(
  parameter int cs_gap_cycles = 4
) (
  input  logic         fsclk,
  input  logic         reset,
  input  logic         start,
  input  serial_word_t word,
  output logic         done,
  output logic         sdata,
  output logic         scs
);

  localparam int bit_w = $clog2(frame_bits);
  localparam int gap_w = (cs_gap_cycles > 1) ? $clog2(cs_gap_cycles) : 1;

  localparam logic [bit_w-1:0] bit_last = bit_w'(frame_bits - 1);
  localparam logic [gap_w-1:0] gap_last = gap_w'(cs_gap_cycles - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_shift,
    st_gap
  } wr_state_t;

  wr_state_t              state;
  logic [frame_bits-1:0]  shreg;
  logic [bit_w-1:0]       bit_cnt;
  logic [gap_w-1:0]       gap_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control and serial outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge fsclk) begin
    if (reset) begin
      state   <= st_idle;
      scs     <= 1'b1;
      sdata   <= 1'b0;
      bit_cnt <= '0;
      gap_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_load;
          end
        end
        st_load: begin // scs still high here, first bit goes out next.
          scs     <= 1'b0;
          sdata   <= shreg[frame_bits-1];
          bit_cnt <= '0;
          state   <= st_shift;
        end
        st_shift: begin
          if (bit_cnt == bit_last) begin
            scs     <= 1'b1;
            sdata   <= 1'b0; // line rests low between frames.
            gap_cnt <= '0;
            state   <= st_gap;
          end else begin
            sdata   <= shreg[frame_bits-1];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: begin
          if (gap_cnt == gap_last) begin
            state <= st_idle;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // the frame is captured when start is taken and then shifted MSB first.
  always_ff @(posedge fsclk) begin
    if (state == st_idle && start) begin
      shreg <= word;
    end else if (state == st_load || state == st_shift) begin
      shreg <= {shreg[frame_bits-2:0], 1'b0};
    end
  end

  assign done = (state == st_gap) && (gap_cnt == gap_last); // last gap cycle.

endmodule

/* logic/adc_setup_top.sv */
`timescale 1ns/1ps

module adc_setup_top
  import adc_reg_pkg::*, serial_link_pkg::*;
#(
  parameter header_t header_pattern = 12'h001,
  parameter int      cs_gap_cycles  = 4
) (
  input  logic       fsclk,
  input  logic       reset,
  input  logic       cfg_we,
  input  reg_index_t cfg_index,
  input  reg_data_t  cfg_data,
  input  logic       calibration_done,
  output logic       setup_done,
  output logic       sdata,
  output logic       scs
);

  reg_index_t   reg_index;
  reg_data_t    reg_data;
  logic         busy;
  serial_word_t word;
  logic         start;
  logic         done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register bank, sequencer, serial writer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  adc_setup_regs u_regs (
    .fsclk     (fsclk),
    .reset     (reset),
    .cfg_we    (cfg_we),
    .cfg_index (cfg_index),
    .cfg_data  (cfg_data),
    .busy      (busy),
    .reg_index (reg_index),
    .reg_data  (reg_data)
  );

  adc_serial_setup #(
    .header_pattern (header_pattern)
  ) u_setup (
    .fsclk            (fsclk),
    .reset            (reset),
    .calibration_done (calibration_done),
    .reg_data         (reg_data),
    .reg_index        (reg_index),
    .busy             (busy),
    .word             (word),
    .start            (start),
    .done             (done),
    .setup_done       (setup_done)
  );

  // the ADC serial clock is fsclk itself, so only sdata and scs leave the chip.
  adc_serial_writer #(
    .cs_gap_cycles (cs_gap_cycles)
  ) u_writer (
    .fsclk (fsclk),
    .reset (reset),
    .start (start),
    .word  (word),
    .done  (done),
    .sdata (sdata),
    .scs   (scs)
  );

endmodule

/* verification/adc_setup_assert.sv */
`timescale 1ns/1ps

module adc_setup_assert
  import serial_link_pkg::*;
#(
  parameter int cs_gap_cycles = 4
) (
  input logic fsclk,
  input logic reset,
  input logic scs,
  input logic sdata,
  input logic setup_done
);

  int   low_run;
  int   high_run;
  logic seen_frame;

  int frame_errs = 0;
  int idle_errs  = 0;
  int done_errs  = 0;
  int gap_errs   = 0;
  int total_errors;

  // run lengths of scs before the current cycle.
  always_ff @(posedge fsclk) begin
    if (reset) begin
      low_run    <= 0;
      high_run   <= 0;
      seen_frame <= 1'b0;
    end else if (!scs) begin
      low_run    <= low_run + 1;
      high_run   <= 0;
      seen_frame <= 1'b1;
    end else begin
      low_run  <= 0;
      high_run <= high_run + 1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // serial port rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assert property (@(posedge fsclk) disable iff (reset) !scs |-> low_run < frame_bits)
    else begin $error("scs held low longer than one frame"); frame_errs++; end

  assert property (@(posedge fsclk) disable iff (reset) scs |-> !sdata)
    else begin $error("sdata high while scs is high"); idle_errs++; end

  assert property (@(posedge fsclk) disable iff (reset) setup_done |=> setup_done)
    else begin $error("setup_done fell without reset"); done_errs++; end

  // the first frame after reset has no gap before it.
  assert property (@(posedge fsclk) disable iff (reset)
                   $fell(scs) && seen_frame |-> high_run >= cs_gap_cycles)
    else begin $error("chip-select gap shorter than cs_gap_cycles"); gap_errs++; end

  always_comb total_errors = frame_errs + idle_errs + done_errs + gap_errs;

endmodule

bind adc_setup_top adc_setup_assert #(
  .cs_gap_cycles (cs_gap_cycles)
) u_assert (
  .fsclk      (fsclk),
  .reset      (reset),
  .scs        (scs),
  .sdata      (sdata),
  .setup_done (setup_done)
);

/* verification/adc_setup_tb.sv */
`timescale 1ns/1ps

module adc_setup_tb
  import adc_reg_pkg::*, serial_link_pkg::*;
();

  localparam header_t tb_header   = 12'h3A5;
  localparam int      tb_gap      = 5;
  localparam int      num_tests   = 5;
  localparam int      exp_low     = 32;
  // scs rests high for the gap, then the idle and load cycles of the writer.
  localparam int      exp_gap     = tb_gap + 2;
  localparam int      cycle_limit = num_tests * 6 * (34 + tb_gap) + 200;

  logic       fsclk;
  logic       reset;
  logic       cfg_we;
  reg_index_t cfg_index;
  reg_data_t  cfg_data;
  logic       calibration_done;
  logic       setup_done;
  logic       sdata;
  logic       scs;

  reg_addr_t exp_addr [6] = '{4'h1, 4'h2, 4'h3, 4'hC, 4'hD, 4'hF};
  reg_data_t exp_default [6] = '{16'h92FF, 16'h007F, 16'h807F, 16'h007F, 16'h03FF, 16'hFFFF};
  reg_data_t model_regs [6]; // host view of the bank.

  int seed = 21607;
  int error_count = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle_count = 0;

  serial_word_t word_q [$];
  int           low_q [$];
  int           gap_q [$];
  logic [31:0]  cap_vec;
  int           cap_bits;
  int           high_run;
  logic         cap_open;
  logic         seen_frame;

  adc_setup_top #(
    .header_pattern (tb_header),
    .cs_gap_cycles  (tb_gap)
  ) uut (
    .fsclk            (fsclk),
    .reset            (reset),
    .cfg_we           (cfg_we),
    .cfg_index        (cfg_index),
    .cfg_data         (cfg_data),
    .calibration_done (calibration_done),
    .setup_done       (setup_done),
    .sdata            (sdata),
    .scs              (scs)
  );

  initial begin
    fsclk = 1'b0;
    forever #10 fsclk = ~fsclk;
  end

  always @(posedge fsclk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame capture on the serial port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge fsclk) begin
    if (reset) begin
      cap_open   = 1'b0;
      seen_frame = 1'b0;
      high_run   = 0;
    end else if (!scs) begin
      if (!cap_open) begin
        if (seen_frame) gap_q.push_back(high_run);
        cap_open = 1'b1;
        cap_bits = 0;
        cap_vec  = '0;
      end
      cap_vec = {cap_vec[30:0], sdata}; // MSB arrives first.
      cap_bits++;
    end else begin
      if (cap_open) begin
        word_q.push_back(serial_word_t'(cap_vec));
        low_q.push_back(cap_bits);
        cap_open   = 1'b0;
        seen_frame = 1'b1;
        high_run   = 0;
      end
      high_run++;
    end
  end

  task automatic check_word(string name, serial_word_t expected, serial_word_t actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_count(string name, int expected, int actual);
    if (actual != expected) begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
      error_count++;
    end
  endtask

  function automatic int all_errors();
    return error_count + uut.u_assert.total_errors;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic model_write(reg_index_t idx, reg_data_t data, logic busy_now);
    if (!busy_now && int'(idx) < 6) begin
      model_regs[idx] = data; // indices 6 and 7 have no register.
    end
  endtask

  task automatic apply_reset();
    @(posedge fsclk);
    #1;
    reset            = 1'b1;
    cfg_we           = 1'b0;
    calibration_done = 1'b0;
    repeat (8) @(posedge fsclk);
    #1;
    reset = 1'b0;
    word_q.delete();
    low_q.delete();
    gap_q.delete();
    for (int i = 0; i < 6; i++) begin
      model_regs[i] = exp_default[i];
    end
  endtask

  task automatic host_write(reg_index_t idx, reg_data_t data, logic busy_now);
    cfg_we    = 1'b1;
    cfg_index = idx;
    cfg_data  = data;
    model_write(idx, data, busy_now);
    @(posedge fsclk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic random_write(logic busy_now);
    reg_index_t idx;
    reg_data_t  data;
    idx  = reg_index_t'($random(seed));
    data = reg_data_t'($random(seed));
    host_write(idx, data, busy_now);
  endtask

  task automatic run_to_done();
    calibration_done = 1'b1;
    while (setup_done !== 1'b1) begin
      @(posedge fsclk);
      #1;
    end
    repeat (2) @(posedge fsclk);
    @(negedge fsclk);
    check_flag("setup_done", 1'b1, setup_done);
  endtask

  task automatic check_frames();
    serial_word_t expected;
    check_count("frame count", 6, word_q.size());
    check_count("gap count", 5, gap_q.size());
    for (int i = 0; i < word_q.size() && i < 6; i++) begin
      expected = '{header: tb_header, addr: exp_addr[i], data: model_regs[i]};
      check_word($sformatf("frame %0d", i), expected, word_q[i]);
      check_count($sformatf("scs low cycles, frame %0d", i), exp_low, low_q[i]);
    end
    foreach (gap_q[i]) begin
      check_count($sformatf("scs gap cycles, gap %0d", i), exp_gap, gap_q[i]);
    end
  endtask

  task automatic finish_test(string name, int errs_before);
    if (all_errors() == errs_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, all_errors() - errs_before);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int errs_before;
    int wait_cycles;
    reset            = 1'b1;
    cfg_we           = 1'b0;
    cfg_index        = '0;
    cfg_data         = '0;
    calibration_done = 1'b0;

    apply_reset();
    errs_before = all_errors();
    run_to_done();
    check_frames();
    finish_test("defaults", errs_before);

    apply_reset();
    errs_before = all_errors();
    repeat (12) random_write(1'b0);
    // indices past the bank are always exercised at least once.
    host_write(3'd6, reg_data_t'($random(seed)), 1'b0);
    host_write(3'd7, reg_data_t'($random(seed)), 1'b0);
    run_to_done();
    check_frames();
    finish_test("random configuration", errs_before);

    apply_reset();
    errs_before = all_errors();
    repeat (4) random_write(1'b0);
    calibration_done = 1'b1;
    while (scs !== 1'b0) begin
      @(posedge fsclk);
      #1;
    end
    while (setup_done !== 1'b1) random_write(1'b1); // bank is locked here.
    run_to_done();
    check_frames();
    finish_test("lock while busy", errs_before);

    apply_reset();
    errs_before = all_errors();
    wait_cycles = 4 + ($random(seed) & 15);
    repeat (wait_cycles) begin
      @(negedge fsclk);
      check_flag("setup_done", 1'b0, setup_done);
    end
    check_count("frames before calibration", 0, word_q.size());
    @(posedge fsclk);
    #1;
    run_to_done();
    check_frames();
    repeat (20) begin
      @(posedge fsclk);
      #1;
      calibration_done = 1'($random(seed));
      @(negedge fsclk);
      check_flag("setup_done", 1'b1, setup_done);
    end
    check_count("frames after setup", 6, word_q.size());
    finish_test("start gating and stickiness", errs_before);

    apply_reset();
    errs_before = all_errors();
    repeat (8) random_write(1'b0);
    run_to_done();
    check_frames();
    finish_test("frame shape", errs_before);

    $display("summary: %0d tests passed, %0d tests failed, %0d errors", tests_passed,
             tests_failed, all_errors());
    if (tests_failed == 0 && all_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
logic/adc_reg_pkg.sv
logic/serial_link_pkg.sv
logic/adc_setup_regs.sv
logic/adc_serial_setup.sv
logic/adc_serial_writer.sv
logic/adc_setup_top.sv
verification/adc_setup_assert.sv
verification/adc_setup_tb.sv

/* Makefile */
TOP := adc_setup_tb
SRC := $(wildcard logic/*.sv verification/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f $(SRC)
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only -Wall logic/adc_reg_pkg.sv logic/serial_link_pkg.sv \
		logic/adc_setup_regs.sv logic/adc_serial_setup.sv logic/adc_serial_writer.sv \
		logic/adc_setup_top.sv --top-module adc_setup_top
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
